// ==== rtl/mult_consts.svh ====
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// operand width of a and b
`define MULT_WIDTH 16

// full unsigned product, never wider than two operands
`define PROD_WIDTH 32

// bits per lookahead group in the final adder
`define CLA_GROUP 4

`endif

// ==== rtl/mult_pkg.sv ====
`include "mult_consts.svh"

package mult_pkg;

    typedef logic [`MULT_WIDTH-1:0] operand_t;

    // also used for one reduction row
    typedef logic [`PROD_WIDTH-1:0] product_t;

    // row i holds b << i when a[i] is set
    typedef product_t [`MULT_WIDTH-1:0] pp_rows_t;

    typedef struct packed {
        logic     valid;
        operand_t a;
        operand_t b;
    } mult_req_t;

    // redundant form out of the tree, product = sum_row + carry_row
    typedef struct packed {
        logic     valid;
        product_t sum_row;
        product_t carry_row;
    } csa_pair_t;

    typedef struct packed {
        logic     valid;
        product_t product;
    } mult_resp_t;

endpackage

// ==== rtl/partial_products.sv ====
`timescale 1ns/100ps
`include "mult_consts.svh"

module partial_products (
    input  mult_pkg::mult_req_t req,
    output mult_pkg::pp_rows_t  rows,
    output logic                rows_valid
);

    assign rows_valid = req.valid;  // no state here

    // each bit of a gates a copy of b shifted up to column i
    always_comb begin
        rows = '0;
        for (int i = 0; i < `MULT_WIDTH; i++) begin
            if (req.a[i]) begin
                rows[i] = mult_pkg::product_t'(req.b) << i;
            end
        end

        for (int i = 0; i < `MULT_WIDTH; i++) begin
            if (!req.a[i]) begin
                assert (rows[i] == '0)
                    else $error("row %0d not zero while a[%0d] is clear", i, i);
            end
        end
    end

endmodule

// ==== rtl/csa_tree.sv ====
`timescale 1ns/100ps
`include "mult_consts.svh"

module csa_tree (
    input  logic                clk,
    input  logic                reset,
    input  mult_pkg::pp_rows_t  rows,
    input  logic                rows_valid,
    output mult_pkg::csa_pair_t pair
);

    // three rows in, two rows out per counter group
    function automatic int rows_after(input int n);
        return (n / 3) * 2 + n % 3;
    endfunction

    function automatic int rows_at(input int layer);
        int n;
        n = `MULT_WIDTH;
        for (int k = 0; k < layer; k++) begin
            n = rows_after(n);
        end
        return n;
    endfunction

    function automatic int layer_count();
        int n;
        int layers;
        n = `MULT_WIDTH;
        layers = 0;
        while (n > 2) begin
            n = rows_after(n);
            layers++;
        end
        return layers;
    endfunction

    localparam int LAYERS = layer_count();  // 16 11 8 6 4 3 2

    mult_pkg::pp_rows_t layer_rows [0:LAYERS];
    mult_pkg::product_t row_total;

    assign layer_rows[0] = rows;

    for (genvar k = 0; k < LAYERS; k++) begin : g_layer
        localparam int N_IN  = rows_at(k);
        localparam int N_GRP = N_IN / 3;
        localparam int N_OUT = rows_at(k + 1);

        for (genvar grp = 0; grp < N_GRP; grp++) begin : g_counter
            mult_pkg::product_t x;
            mult_pkg::product_t y;
            mult_pkg::product_t z;

            assign x = layer_rows[k][3*grp];
            assign y = layer_rows[k][3*grp+1];
            assign z = layer_rows[k][3*grp+2];

            // full adder per column
            assign layer_rows[k+1][2*grp]   = x ^ y ^ z;
            assign layer_rows[k+1][2*grp+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        // leftover rows skip this layer
        for (genvar r = 0; r < N_IN - 3 * N_GRP; r++) begin : g_pass
            assign layer_rows[k+1][2*N_GRP+r] = layer_rows[k][3*N_GRP+r];
        end

        for (genvar r = N_OUT; r < `MULT_WIDTH; r++) begin : g_empty
            assign layer_rows[k+1][r] = '0;
        end
    end

    // first pipeline stage
    always_ff @(posedge clk) begin
        pair.sum_row   <= layer_rows[LAYERS][0];
        pair.carry_row <= layer_rows[LAYERS][1];
        if (reset) begin
            pair.valid <= 1'b0;
        end else begin
            pair.valid <= rows_valid;
        end
    end

    // plain sum of the rows, reference for the tree
    always_comb begin
        row_total = '0;
        for (int i = 0; i < `MULT_WIDTH; i++) begin
            row_total = row_total + rows[i];
        end
    end

    // carries pushed past bit 31 are always zero for a 16x16 product
    a_tree_sum: assert property (
        @(posedge clk) disable iff (reset)
        pair.valid |-> mult_pkg::product_t'(pair.sum_row + pair.carry_row) == $past(row_total)
    ) else $error("tree rows do not add up to the partial products");

endmodule

// ==== rtl/cla_adder.sv ====
`timescale 1ns/100ps
`include "mult_consts.svh"

module cla_adder (
    input  logic                 clk,
    input  logic                 reset,
    input  mult_pkg::csa_pair_t  pair,
    output mult_pkg::mult_resp_t resp
);

    localparam int GROUPS = `PROD_WIDTH / `CLA_GROUP;

    // carry into bit j of a group, flattened sum of products
    function automatic logic group_carry(
        input logic [`CLA_GROUP-1:0] gv,
        input logic [`CLA_GROUP-1:0] pv,
        input logic                  cin,
        input int                    j
    );
        logic carry;
        logic term;
        carry = cin;
        for (int n = 0; n < j; n++) begin
            carry = carry & pv[n];
        end
        for (int m = 0; m < j; m++) begin
            term = gv[m];
            for (int n = m + 1; n < j; n++) begin
                term = term & pv[n];
            end
            carry = carry | term;
        end
        return carry;
    endfunction

    logic [`PROD_WIDTH-1:0] bit_g;
    logic [`PROD_WIDTH-1:0] bit_p;
    logic [`PROD_WIDTH-1:0] bit_c;
    logic [GROUPS-1:0]      grp_g;
    logic [GROUPS-1:0]      grp_p;
    logic [GROUPS:0]        grp_c;
    logic                   carry_out;
    mult_pkg::product_t     sum;

    assign bit_g = pair.sum_row & pair.carry_row;
    assign bit_p = pair.sum_row ^ pair.carry_row;

    assign grp_c[0] = 1'b0;

    for (genvar k = 0; k < GROUPS; k++) begin : g_group
        logic [`CLA_GROUP-1:0] gv;
        logic [`CLA_GROUP-1:0] pv;

        assign gv = bit_g[k*`CLA_GROUP +: `CLA_GROUP];
        assign pv = bit_p[k*`CLA_GROUP +: `CLA_GROUP];

        for (genvar j = 0; j < `CLA_GROUP; j++) begin : g_bit
            assign bit_c[k*`CLA_GROUP+j] = group_carry(gv, pv, grp_c[k], j);
        end

        assign grp_g[k] = group_carry(gv, pv, 1'b0, `CLA_GROUP);
        assign grp_p[k] = &pv;

        // groups ripple
        assign grp_c[k+1] = grp_g[k] | (grp_p[k] & grp_c[k]);
    end

    assign sum       = bit_p ^ bit_c;
    assign carry_out = grp_c[GROUPS];

    // second pipeline stage
    always_ff @(posedge clk) begin
        if (pair.valid) begin
            resp.product <= sum;
        end
        if (reset) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= pair.valid;
        end
    end

    // the product of two 16 bit operands fits in 32 bits
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        pair.valid |-> !carry_out
    ) else $error("carry out of bit 31 on a valid pair");

    a_valid_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(resp.valid)
    ) else $error("resp.valid unknown after reset");

endmodule

// ==== rtl/mult_pipe.sv ====
`timescale 1ns/100ps

module mult_pipe (
    input  logic                 clk,
    input  logic                 reset,
    input  mult_pkg::mult_req_t  req,
    output mult_pkg::mult_resp_t resp
);

    mult_pkg::pp_rows_t  rows;
    logic                rows_valid;
    mult_pkg::csa_pair_t pair;  // registered, stage 1

    // combinational, same cycle as req
    partial_products u_products (
        .req        (req),
        .rows       (rows),
        .rows_valid (rows_valid)
    );

    csa_tree u_tree (
        .clk        (clk),
        .reset      (reset),
        .rows       (rows),
        .rows_valid (rows_valid),
        .pair       (pair)
    );

    // resp two cycles after req
    cla_adder u_adder (
        .clk   (clk),
        .reset (reset),
        .pair  (pair),
        .resp  (resp)
    );

endmodule

// ==== verif/tb_mult.sv ====
`timescale 1ns/100ps
`include "mult_consts.svh"

module tb_mult;

    // reset 16 + corners 5 + walking 256 + burst 500 + gapped ~400 + drains ~25
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int BURST_COUNT    = 500;
    localparam int GAPPED_COUNT   = 200;
    localparam int DRAIN_CYCLES   = 4;

    logic                 clk;
    logic                 reset;
    mult_pkg::mult_req_t  req;
    mult_pkg::mult_resp_t resp;

    logic [31:0] lcg_state;
    string       test_name;
    int          cycle_count   = 0;
    int          requests_sent = 0;
    int          results_seen  = 0;

    // request history, one and two cycles back
    logic               valid_d1  = 1'b0;
    logic               valid_d2  = 1'b0;
    mult_pkg::product_t expect_d1 = '0;
    mult_pkg::product_t expect_d2 = '0;

    mult_pipe DUT (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .resp  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // full 32 bit product of each request, lined up with resp
    always @(posedge clk) begin
        valid_d1  <= req.valid;
        valid_d2  <= valid_d1;
        expect_d1 <= mult_pkg::product_t'(req.a) * mult_pkg::product_t'(req.b);
        expect_d2 <= expect_d1;
    end

    always @(posedge clk) begin
        if (!reset && resp.valid) begin
            results_seen <= results_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // first edge is skipped, resp is still unknown there
    a_reset_quiet: assert property (
        @(posedge clk) (reset && cycle_count > 0) |-> !resp.valid
    ) else begin
        $display("resp.valid went high while reset was asserted");
        $display("Errors found");
        $fatal(1, "output active during reset");
    end

    a_valid_timing: assert property (
        @(posedge clk) disable iff (reset)
        resp.valid == valid_d2
    ) else begin
        $display("FAILED %s resp.valid expected %b actual %b",
                 test_name, $sampled(valid_d2), $sampled(resp.valid));
        $display("Errors found");
        $fatal(1, "valid timing mismatch");
    end

    a_product_value: assert property (
        @(posedge clk) disable iff (reset)
        resp.valid |-> resp.product == expect_d2
    ) else begin
        $display("FAILED %s product expected %h actual %h",
                 test_name, $sampled(expect_d2), $sampled(resp.product));
        $display("Errors found");
        $fatal(1, "product mismatch");
    end

    a_product_known: assert property (
        @(posedge clk) disable iff (reset)
        resp.valid |-> !$isunknown(resp.product)
    ) else begin
        $display("Product has unknown bits while resp.valid is high in %s", test_name);
        $display("Errors found");
        $fatal(1, "unknown product");
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one request per falling edge
    task automatic send(
        input logic               valid,
        input mult_pkg::operand_t a,
        input mult_pkg::operand_t b
    );
        @(negedge clk);
        req.valid = valid;
        req.a     = a;
        req.b     = b;
        if (valid) begin
            requests_sent++;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            send(1'b0, '0, '0);
        end
    endtask

    task automatic send_random(input logic valid);
        mult_pkg::operand_t a;
        mult_pkg::operand_t b;
        lcg_state = lcg_next(lcg_state);
        a = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[31:16];
        send(valid, a, b);
    endtask

    task automatic apply_reset();
        test_name = "reset";
        reset = 1'b1;
        repeat (16) begin
            @(negedge clk);
        end
        reset = 1'b0;
        idle(DRAIN_CYCLES);  // resp.valid must stay low with no requests
    endtask

    task automatic run_corners();
        test_name = "corner_operands";
        send(1'b1, 16'h0000, 16'h0000);
        send(1'b1, 16'h0000, 16'hffff);
        send(1'b1, 16'h0001, 16'hffff);
        send(1'b1, 16'hffff, 16'hffff);  // ffff * ffff = fffe0001
        send(1'b1, 16'h8000, 16'h8000);  // 8000 * 8000 = 40000000
        idle(DRAIN_CYCLES);
    endtask

    // one bit in each operand, product is a single bit at i + j
    task automatic run_walking_ones();
        mult_pkg::operand_t a;
        mult_pkg::operand_t b;
        test_name = "walking_ones";
        for (int i = 0; i < `MULT_WIDTH; i++) begin
            for (int j = 0; j < `MULT_WIDTH; j++) begin
                a = mult_pkg::operand_t'(1) << i;
                b = mult_pkg::operand_t'(1) << j;
                send(1'b1, a, b);
            end
        end
        idle(DRAIN_CYCLES);
    endtask

    task automatic run_burst(input int count);
        test_name = "back_to_back";
        for (int n = 0; n < count; n++) begin
            send_random(1'b1);
        end
        idle(DRAIN_CYCLES);
    endtask

    // lcg picks each cycle whether a request goes out
    task automatic run_gapped(input int count);
        int sent;
        sent = 0;
        test_name = "gapped";
        while (sent < count) begin
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[28]) begin
                send_random(1'b1);
                sent++;
            end else begin
                send_random(1'b0);
            end
        end
        idle(DRAIN_CYCLES);
    endtask

    initial begin
        req       = '0;
        reset     = 1'b1;
        lcg_state = 32'h7e3;
        test_name = "init";

        apply_reset();
        run_corners();
        run_walking_ones();
        run_burst(BURST_COUNT);
        run_gapped(GAPPED_COUNT);

        test_name = "drain";
        @(negedge clk);
        if (results_seen != requests_sent) begin
            $display("FAILED %s result count expected %0d actual %0d",
                     test_name, requests_sent, results_seen);
            $display("Errors found");
            $fatal(1, "result count mismatch");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/mult_pkg.sv
rtl/partial_products.sv
rtl/csa_tree.sv
rtl/cla_adder.sv
rtl/mult_pipe.sv
verif/tb_mult.sv

// ==== Makefile ====
TOP := tb_mult

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
	verilator --binary --assert --timing --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --assert --timing --top-module $(TOP) -f sources.f
	verilator --lint-only --assert -Irtl --top-module mult_pipe \
		rtl/mult_pkg.sv rtl/partial_products.sv rtl/csa_tree.sv \
		rtl/cla_adder.sv rtl/mult_pipe.sv

clean:
	rm -rf obj_dir
